//--- logic/rv_core_pkg.sv
package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [ILEN-1:0] inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       op_a;
        logic [XLEN-1:0]       op_b;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        alu_op_e               alu_op;
        logic                  is_load;
        logic                  is_store;
        logic                  rf_we;
    } decode_pkt_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  is_load;
        logic                  is_store;
        logic                  rf_we;
    } exec_pkt_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       wb_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rf_we;
    } wb_pkt_t;

    // One retired instruction as seen from outside the core
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
        logic                  we;
    } commit_t;

endpackage

//--- logic/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o,
    input  logic [REG_ADDR_W-1:0] wr_addr_i,
    input  logic [XLEN-1:0]       wr_data_i,
    input  logic                  wr_en_i
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

//--- logic/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            pc_wen_i,
    input  logic [XLEN-1:0] next_pc_i,
    output logic            imem_req_o,
    output logic [XLEN-1:0] imem_addr_o,
    input  logic [ILEN-1:0] imem_rdata_i,
    output logic            fetch_valid_o,
    output fetch_pkt_t      fetch_o
);

    logic [XLEN-1:0] pc_q;
    logic            boot_q;
    logic            req_q;
    // Word for the current PC arrives this cycle
    logic            pend_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q   <= RESET_PC;
            boot_q <= 1'b1;
            req_q  <= 1'b0;
            pend_q <= 1'b0;
        end else begin
            boot_q <= 1'b0;
            req_q  <= boot_q || pc_wen_i;
            pend_q <= req_q;
            if (pc_wen_i) begin
                pc_q <= next_pc_i;
            end
        end
    end

    assign imem_req_o  = req_q;
    assign imem_addr_o = pc_q;

    // PC stays put until writeback, so it still matches the returned word
    assign fetch_valid_o = pend_q;
    assign fetch_o.pc    = pc_q;
    assign fetch_o.inst  = imem_rdata_i;

endmodule

//--- logic/rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  fetch_valid_i,
    input  fetch_pkt_t            fetch_i,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    output logic                  dec_valid_o,
    output decode_pkt_t           dec_o,
    output logic [XLEN-1:0]       next_pc_o
);

    logic [ILEN-1:0]       inst;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd_field;
    logic [XLEN-1:0]       imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [XLEN-1:0]       pc_plus4;
    logic [XLEN-1:0]       jump_tgt;
    logic                  take_jump;
    logic                  wants_rd;
    logic                  is_word;
    decode_pkt_t           dec_d;

    assign inst     = fetch_i.inst;
    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign rd_field = inst[11:7];
    assign is_word  = (funct3 == 3'b010);
    assign pc_plus4 = fetch_i.pc + 32'd4;

    assign rs1_addr_o = inst[19:15];
    assign rs2_addr_o = inst[24:20];

    // Immediates sign extended from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec_d            = '0;
        dec_d.pc         = fetch_i.pc;
        dec_d.op_a       = rs1_data_i;
        dec_d.op_b       = imm_i;
        dec_d.store_data = rs2_data_i;
        dec_d.alu_op     = ALU_ADD;
        wants_rd         = 1'b0;
        take_jump        = 1'b0;
        jump_tgt         = fetch_i.pc + imm_b;
        case (opcode)
            OPC_OP: begin
                dec_d.op_b = rs2_data_i;
                wants_rd   = 1'b1;
                case (funct3)
                    3'b000:  dec_d.alu_op = inst[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  dec_d.alu_op = ALU_SLT;
                    3'b100:  dec_d.alu_op = ALU_XOR;
                    3'b110:  dec_d.alu_op = ALU_OR;
                    3'b111:  dec_d.alu_op = ALU_AND;
                    default: wants_rd     = 1'b0;
                endcase
            end
            // Only ADDI in this subset
            OPC_OP_IMM: wants_rd = (funct3 == 3'b000);
            OPC_LUI: begin
                dec_d.op_b   = imm_u;
                dec_d.alu_op = ALU_PASS_B;
                wants_rd     = 1'b1;
            end
            OPC_LOAD: begin
                dec_d.is_load = is_word;
                wants_rd      = is_word;
            end
            OPC_STORE: begin
                dec_d.op_b     = imm_s;
                dec_d.is_store = is_word;
            end
            OPC_BRANCH: begin
                if (funct3 == 3'b000) begin
                    take_jump = (rs1_data_i == rs2_data_i);
                end else if (funct3 == 3'b001) begin
                    take_jump = (rs1_data_i != rs2_data_i);
                end
            end
            OPC_JAL: begin
                // Link value rides through the ALU as operand B
                dec_d.op_b   = pc_plus4;
                dec_d.alu_op = ALU_PASS_B;
                wants_rd     = 1'b1;
                take_jump    = 1'b1;
                jump_tgt     = fetch_i.pc + imm_j;
            end
            default: ;
        endcase
        dec_d.rf_we = wants_rd && (rd_field != '0);
        dec_d.rd    = dec_d.rf_we ? rd_field : '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
            next_pc_o   <= RESET_PC;
        end else begin
            dec_valid_o <= fetch_valid_i;
            if (fetch_valid_i) begin
                next_pc_o <= take_jump ? jump_tgt : pc_plus4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid_i) begin
            dec_o <= dec_d;
        end
    end

endmodule

//--- logic/rv_execute.sv
`timescale 1ns/1ps

module rv_execute import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        dec_valid_i,
    input  decode_pkt_t dec_i,
    output logic        exe_valid_o,
    output exec_pkt_t   exe_o
);

    logic [XLEN-1:0] alu_res;

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:    alu_res = dec_i.op_a + dec_i.op_b;
            ALU_SUB:    alu_res = dec_i.op_a - dec_i.op_b;
            ALU_AND:    alu_res = dec_i.op_a & dec_i.op_b;
            ALU_OR:     alu_res = dec_i.op_a | dec_i.op_b;
            ALU_XOR:    alu_res = dec_i.op_a ^ dec_i.op_b;
            // Signed compare
            ALU_SLT:    alu_res = {31'b0, $signed(dec_i.op_a) < $signed(dec_i.op_b)};
            ALU_PASS_B: alu_res = dec_i.op_b;
            default:    alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            exe_valid_o <= 1'b0;
        end else begin
            exe_valid_o <= dec_valid_i;
        end
    end

    // Result doubles as the data address for loads and stores
    always_ff @(posedge clk) begin
        if (dec_valid_i) begin
            exe_o.pc         <= dec_i.pc;
            exe_o.result     <= alu_res;
            exe_o.store_data <= dec_i.store_data;
            exe_o.rd         <= dec_i.rd;
            exe_o.is_load    <= dec_i.is_load;
            exe_o.is_store   <= dec_i.is_store;
            exe_o.rf_we      <= dec_i.rf_we;
        end
    end

endmodule

//--- logic/rv_memory.sv
`timescale 1ns/1ps

module rv_memory import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      exe_valid_i,
    input  exec_pkt_t exe_i,
    output logic      mem_valid_o,
    output wb_pkt_t   mem_o
);

    logic [XLEN-1:0]       dmem [DMEM_WORDS];
    logic [DMEM_IDX_W-1:0] word_idx;

    // Word index from the address bits above bit 1
    assign word_idx = exe_i.result[DMEM_IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_valid_o <= 1'b0;
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else begin
            mem_valid_o <= exe_valid_i;
            if (exe_valid_i && exe_i.is_store) begin
                dmem[word_idx] <= exe_i.store_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid_i) begin
            mem_o.pc      <= exe_i.pc;
            mem_o.wb_data <= exe_i.is_load ? dmem[word_idx] : exe_i.result;
            mem_o.rd      <= exe_i.rd;
            mem_o.rf_we   <= exe_i.rf_we;
        end
    end

endmodule

//--- logic/rv_writeback.sv
`timescale 1ns/1ps

module rv_writeback import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  mem_valid_i,
    input  wb_pkt_t               mem_i,
    output logic [REG_ADDR_W-1:0] rf_wr_addr_o,
    output logic [XLEN-1:0]       rf_wr_data_o,
    output logic                  rf_wr_en_o,
    output logic                  commit_valid_o,
    output commit_t               commit_o,
    output logic                  pc_wen_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rf_wr_en_o     <= 1'b0;
            commit_valid_o <= 1'b0;
            pc_wen_o       <= 1'b0;
        end else begin
            rf_wr_en_o     <= mem_valid_i && mem_i.rf_we;
            commit_valid_o <= mem_valid_i;
            // Retirement releases the next fetch
            pc_wen_o       <= mem_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid_i) begin
            rf_wr_addr_o  <= mem_i.rd;
            rf_wr_data_o  <= mem_i.wb_data;
            commit_o.pc   <= mem_i.pc;
            commit_o.rd   <= mem_i.rd;
            // Data is reported only when a register is written
            commit_o.data <= mem_i.rf_we ? mem_i.wb_data : '0;
            commit_o.we   <= mem_i.rf_we;
        end
    end

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    output logic            imem_req_o,
    output logic [XLEN-1:0] imem_addr_o,
    input  logic [ILEN-1:0] imem_rdata_i,
    output logic            commit_valid_o,
    output commit_t         commit_o
);

    // Stage strobes and packets
    logic        fetch_valid;
    fetch_pkt_t  fetch_pkt;
    logic        dec_valid;
    decode_pkt_t dec_pkt;
    logic        exe_valid;
    exec_pkt_t   exe_pkt;
    logic        mem_valid;
    wb_pkt_t     mem_pkt;

    logic [XLEN-1:0] next_pc;
    logic            pc_wen;

    // Register file ports
    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr, rf_wr_addr;
    logic [XLEN-1:0]       rs1_data, rs2_data, rf_wr_data;
    logic                  rf_wr_en;

    rv_regfile i_rv_regfile (
        .clk        (clk),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_addr_i  (rf_wr_addr),
        .wr_data_i  (rf_wr_data),
        .wr_en_i    (rf_wr_en)
    );

    rv_fetch i_rv_fetch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .pc_wen_i      (pc_wen),
        .next_pc_i     (next_pc),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .imem_rdata_i  (imem_rdata_i),
        .fetch_valid_o (fetch_valid),
        .fetch_o       (fetch_pkt)
    );

    rv_decode i_rv_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_valid_i (fetch_valid),
        .fetch_i       (fetch_pkt),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .dec_valid_o   (dec_valid),
        .dec_o         (dec_pkt),
        .next_pc_o     (next_pc)
    );

    rv_execute i_rv_execute (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .dec_valid_i (dec_valid),
        .dec_i       (dec_pkt),
        .exe_valid_o (exe_valid),
        .exe_o       (exe_pkt)
    );

    rv_memory i_rv_memory (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .exe_valid_i (exe_valid),
        .exe_i       (exe_pkt),
        .mem_valid_o (mem_valid),
        .mem_o       (mem_pkt)
    );

    rv_writeback i_rv_writeback (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .mem_valid_i    (mem_valid),
        .mem_i          (mem_pkt),
        .rf_wr_addr_o   (rf_wr_addr),
        .rf_wr_data_o   (rf_wr_data),
        .rf_wr_en_o     (rf_wr_en),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o),
        .pc_wen_o       (pc_wen)
    );

endmodule

//--- verification/rv_core_assert.sv
`timescale 1ns/1ps

module rv_core_assert import rv_core_pkg::*; (
    input logic    clk,
    input logic    rst_n_i,
    input logic    imem_req_i,
    input logic    commit_valid_i,
    input commit_t commit_i
);

    int   fail_count = 0;
    // High from instruction request until its commit
    logic in_flight;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            in_flight <= 1'b0;
        end else if (imem_req_i) begin
            in_flight <= 1'b1;
        end else if (commit_valid_i) begin
            in_flight <= 1'b0;
        end
    end

    commit_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_i |=> !commit_valid_i)
        else begin
            $error("commit_valid held longer than one cycle");
            fail_count++;
        end

    req_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        imem_req_i |=> !imem_req_i)
        else begin
            $error("imem_req held longer than one cycle");
            fail_count++;
        end

    one_in_flight: assert property (@(posedge clk) disable iff (!rst_n_i)
        imem_req_i |-> !in_flight)
        else begin
            $error("instruction request while another instruction is in flight");
            fail_count++;
        end

    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        (commit_valid_i && commit_i.we) |-> (commit_i.rd != '0))
        else begin
            $error("commit reports a write to x0");
            fail_count++;
        end

endmodule

bind rv_core rv_core_assert i_rv_core_assert (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .imem_req_i     (imem_req_o),
    .commit_valid_i (commit_valid_o),
    .commit_i       (commit_o)
);

//--- verification/rv_commit_checker.sv
`timescale 1ns/1ps

module rv_commit_checker import rv_core_pkg::*; #(
    parameter int         TD_WORDS  = 512,
    parameter logic [8:0] REC_START = 9'h100
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        commit_valid_i,
    input  commit_t     commit_i,
    input  logic [31:0] tdata_i [TD_WORDS],
    output logic        done_o,
    output int          tests_passed_o,
    output int          tests_failed_o
);

    // Each record is five words of test, pc, rd, data and we
    logic [8:0]  ptr;
    logic [31:0] exp_test;
    logic [31:0] exp_pc;
    logic [31:0] exp_rd;
    logic [31:0] exp_data;
    logic [31:0] exp_we;
    logic        test_bad;
    string       exp_str;
    string       act_str;

    function automatic string test_name(input logic [31:0] num);
        case (num)
            32'd1:   return "alu";
            32'd2:   return "lui_x0";
            32'd3:   return "memory";
            32'd4:   return "branch";
            32'd5:   return "jal";
            default: return "unknown";
        endcase
    endfunction

    // Commit outputs are registered and settle before the falling edge
    always @(negedge clk) begin
        if (!rst_n_i) begin
            ptr            = REC_START;
            test_bad       = 1'b0;
            done_o         = 1'b0;
            tests_passed_o = 0;
            tests_failed_o = 0;
        end else if (commit_valid_i && !done_o) begin
            exp_test = tdata_i[ptr];
            exp_pc   = tdata_i[ptr + 9'd1];
            exp_rd   = tdata_i[ptr + 9'd2];
            exp_data = tdata_i[ptr + 9'd3];
            exp_we   = tdata_i[ptr + 9'd4];
            if (commit_i.pc !== exp_pc || commit_i.rd !== exp_rd[4:0]
                    || commit_i.data !== exp_data || commit_i.we !== exp_we[0]) begin
                exp_str = $sformatf("pc=%h rd=%0d data=%h we=%0d",
                                    exp_pc, exp_rd[4:0], exp_data, exp_we[0]);
                act_str = $sformatf("pc=%h rd=%0d data=%h we=%0d",
                                    commit_i.pc, commit_i.rd, commit_i.data, commit_i.we);
                $display("ERR %s: expected %s, actual %s", test_name(exp_test), exp_str,
                         act_str);
                test_bad = 1'b1;
            end
            ptr = ptr + 9'd5;
            // Test number changes after its last record
            if (tdata_i[ptr] != exp_test) begin
                if (test_bad) begin
                    $display("test %0d %s: failed", exp_test, test_name(exp_test));
                    tests_failed_o = tests_failed_o + 1;
                end else begin
                    $display("test %0d %s: passed", exp_test, test_name(exp_test));
                    tests_passed_o = tests_passed_o + 1;
                end
                test_bad = 1'b0;
                done_o   = (tdata_i[ptr] == 32'h0);
            end
        end
    end

endmodule

//--- verification/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb import rv_core_pkg::*; ();

    localparam int              TD_WORDS       = 512;
    localparam logic [8:0]      REC_START      = 9'h100;
    localparam logic [XLEN-1:0] PROG_BYTES     = 32'h400;
    localparam int              MAX_RECS       = 50;
    localparam int              RESET_CYCLES   = 10;
    localparam int              CYCLES_PER_REC = 6;
    localparam int              MARGIN         = 50;
    localparam int              IN_DELAY       = 10;

    logic            clk;
    logic            rst_n;
    logic            imem_req;
    logic [XLEN-1:0] imem_addr;
    logic [ILEN-1:0] imem_rdata;
    logic            commit_valid;
    commit_t         commit;

    // Program from word 0, expected commit records from REC_START
    logic [31:0]     tdata [TD_WORDS];
    logic            req_seen;
    logic [XLEN-1:0] req_addr;
    logic            done;
    int              tests_passed;
    int              tests_failed;
    int              assert_fails;
    int              rec_count;
    int              cycle_limit;
    int              cycles = 0;
    logic [8:0]      scan;

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    rv_core i_rv_core (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .imem_req_o     (imem_req),
        .imem_addr_o    (imem_addr),
        .imem_rdata_i   (imem_rdata),
        .commit_valid_o (commit_valid),
        .commit_o       (commit)
    );

    rv_commit_checker #(
        .TD_WORDS  (TD_WORDS),
        .REC_START (REC_START)
    ) i_rv_commit_checker (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .commit_valid_i (commit_valid),
        .commit_i       (commit),
        .tdata_i        (tdata),
        .done_o         (done),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed)
    );

    function automatic logic [ILEN-1:0] program_word(input logic [XLEN-1:0] addr);
        if (addr < PROG_BYTES) begin
            return tdata[{1'b0, addr[9:2]}];
        end
        // NOP outside the program area
        return 32'h00000013;
    endfunction

    // Request seen in cycle n is answered early in cycle n+1
    always @(negedge clk) begin
        req_seen = imem_req;
        req_addr = imem_addr;
    end

    always @(posedge clk) begin
        #IN_DELAY;
        if (req_seen) begin
            imem_rdata = program_word(req_addr);
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        imem_rdata = 32'h00000013;
        $readmemh("verification/rv_core_testdata.hex", tdata);
        rec_count = 0;
        scan      = REC_START;
        // Record list ends at a test number of zero
        while (rec_count < MAX_RECS && tdata[scan] != 32'h0) begin
            rec_count = rec_count + 1;
            scan      = scan + 9'd5;
        end
        cycle_limit = rec_count * CYCLES_PER_REC + RESET_CYCLES + MARGIN;
        repeat (RESET_CYCLES) @(posedge clk);
        #IN_DELAY;
        rst_n = 1'b1;
        while (!done && cycles < cycle_limit) begin
            @(posedge clk);
        end
        assert_fails = i_rv_core.i_rv_core_assert.fail_count;
        if (!done) begin
            $display("Timeout: the core stopped committing after %0d cycles", cycles);
        end
        $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, assert_fails);
        if (done && tests_failed == 0 && assert_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- verification/rv_core_testdata.hex
// Words from @000: program, one instruction per word, PC = 4 * word index
// Words from @100: expected commits as test, pc, rd, data, we; test 0 ends the list
@000
00500093 FFD00113 002081B3 40208233 // addi x1 5, addi x2 -3, add, sub
0020F2B3 0020E333 0020C3B3 00112433 // and, or, xor, slt x8 x2 x1
0020A4B3 12345537 00708013 001005B3 // slt x9 x1 x2, lui x10, addi x0, add x11 x0 x1
00A02423 00802603 01002683          // sw x10 8, lw x12 8, lw x13 16
00B08463 00100713 00209463 00200713 // beq taken, skipped, bne taken, skipped
00208463 00B09463 00300713          // beq not taken, bne not taken, addi x14 3
00C007EF 00100813 00200813 00900813 // jal x15 +12, skipped, skipped, addi x16 9
0000006F                            // jal x0 0 parks the core
@100
1 00000000 01 00000005 1
1 00000004 02 FFFFFFFD 1
1 00000008 03 00000002 1
1 0000000C 04 00000008 1
1 00000010 05 00000005 1
1 00000014 06 FFFFFFFD 1
1 00000018 07 FFFFFFF8 1
1 0000001C 08 00000001 1
1 00000020 09 00000000 1
2 00000024 0A 12345000 1
2 00000028 00 00000000 0
2 0000002C 0B 00000005 1
3 00000030 00 00000000 0
3 00000034 0C 12345000 1
3 00000038 0D 00000000 1
4 0000003C 00 00000000 0
4 00000044 00 00000000 0
4 0000004C 00 00000000 0
4 00000050 00 00000000 0
4 00000054 0E 00000003 1
5 00000058 0F 0000005C 1
5 00000064 10 00000009 1
5 00000068 00 00000000 0
0 00000000 00 00000000 0

//--- compile.f
logic/rv_core_pkg.sv
logic/rv_regfile.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_memory.sv
logic/rv_writeback.sv
logic/rv_core.sv
verification/rv_core_assert.sv
verification/rv_commit_checker.sv
verification/rv_core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module rv_core_tb -f compile.f -o rv_core_sim
./obj_dir/rv_core_sim | tee sim.log
grep -q "^>>> PASS$" sim.log
echo "Simulation passed"
